/* common/queue_table_pkg.sv */
package queue_table_pkg;

    // queue, table and register counts
    localparam int NB_PKT_QUEUES    = 16;
    localparam int NB_DSC_QUEUES    = 16;
    localparam int NB_TABLES        = 4;
    localparam int NB_CONTROL_REGS  = 8;
    localparam int TABLE_RD_LATENCY = 2;

    // word and index widths
    localparam int REG_WIDTH       = 32;
    localparam int BE_PER_WORD     = REG_WIDTH / 8;
    localparam int QUEUE_IDX_WIDTH = $clog2(NB_PKT_QUEUES);
    localparam int PAGE_IDX_WIDTH  = $clog2(NB_PKT_QUEUES + NB_DSC_QUEUES);
    localparam int TABLE_SEL_WIDTH = $clog2(NB_TABLES);
    localparam int CTRL_IDX_WIDTH  = $clog2(NB_CONTROL_REGS);

    // host MMIO port, queue region is bit 17 clear, page in bits 16..12
    localparam int MMIO_ADDR_WIDTH = 18;
    localparam int MMIO_DATA_WIDTH = 512;
    localparam int MMIO_BE_WIDTH   = MMIO_DATA_WIDTH / 8;
    localparam int MMIO_REGION_BIT = 17;
    localparam int MMIO_PAGE_LSB   = 12;

    // APB management port, word index in bits 9..2
    localparam int APB_ADDR_WIDTH  = 10;
    localparam int APB_WORD_LSB    = 2;
    localparam int APB_WORD_WIDTH  = APB_ADDR_WIDTH - APB_WORD_LSB;
    localparam int MGMT_TABLE_BASE = NB_CONTROL_REGS;
    localparam int MGMT_TABLE_END  =
        MGMT_TABLE_BASE + NB_TABLES * (NB_PKT_QUEUES + NB_DSC_QUEUES);

    typedef logic [REG_WIDTH-1:0]       reg_word_t;
    typedef logic [QUEUE_IDX_WIDTH-1:0] queue_idx_t;
    typedef logic [PAGE_IDX_WIDTH-1:0]  page_idx_t;
    typedef logic [TABLE_SEL_WIDTH-1:0] table_sel_t;
    typedef logic [MMIO_ADDR_WIDTH-1:0] mmio_addr_t;
    typedef logic [MMIO_DATA_WIDTH-1:0] mmio_data_t;
    typedef logic [MMIO_BE_WIDTH-1:0]   mmio_be_t;
    typedef logic [APB_ADDR_WIDTH-1:0]  apb_addr_t;

    // tails is table 0 and is never written by the host
    localparam table_sel_t TBL_TAILS = '0;

    // one command to one table memory
    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        queue_idx_t addr;
        reg_word_t  wr_data;
    } table_cmd_t;

    // management request towards the arbiter
    typedef struct packed {
        logic       valid;
        logic       write;
        table_sel_t sel;
        page_idx_t  page;
        reg_word_t  data;
    } mgmt_req_t;

    typedef reg_word_t [NB_CONTROL_REGS-1:0] ctrl_regs_t;

endpackage

/* verilog/queue_table_ram.sv */
`timescale 1ns/100ps

module queue_table_ram import queue_table_pkg::*; (
    input  logic       pcie_clk,
    input  table_cmd_t cmd,
    output reg_word_t  rd_data
);

    // one word per queue of the bank
    reg_word_t  mem [2**QUEUE_IDX_WIDTH];
    queue_idx_t rd_addr_q;

    always_ff @(posedge pcie_clk) begin
        if (cmd.wr_en) begin
            mem[cmd.addr] <= cmd.wr_data;
        end
    end

    // first read stage latches the address
    always_ff @(posedge pcie_clk) begin
        if (cmd.rd_en) begin
            rd_addr_q <= cmd.addr;
        end
    end

    // second stage registers the word, so data shows two cycles after rd_en
    always_ff @(posedge pcie_clk) begin
        rd_data <= mem[rd_addr_q];
    end

endmodule

/* arbiter/table_port_arbiter.sv */
`timescale 1ns/100ps

module table_port_arbiter import queue_table_pkg::*; (
    input  logic       pcie_clk,
    input  logic       pcie_reset_n,

    // host MMIO
    input  mmio_addr_t mmio_address,
    input  logic       mmio_write,
    input  logic       mmio_read,
    input  mmio_data_t mmio_writedata,
    input  mmio_be_t   mmio_byteenable,
    output mmio_data_t mmio_readdata,
    output logic       mmio_readdatavalid,

    // management side
    input  mgmt_req_t  mgmt_req,
    output logic       mgmt_grant,
    output logic       mgmt_rd_valid,
    output reg_word_t  mgmt_rd_data,

    // table memories
    output table_cmd_t pkt_cmd [NB_TABLES],
    output table_cmd_t dsc_cmd [NB_TABLES],
    input  reg_word_t  pkt_rd_data [NB_TABLES],
    input  reg_word_t  dsc_rd_data [NB_TABLES]
);

    // tag that follows a read through the memory latency
    typedef struct packed {
        logic       valid;
        logic       mmio;
        logic       dsc;
        table_sel_t sel;
    } ret_tag_t;

    page_idx_t  mmio_page;
    logic       mmio_in_region;
    logic       wr_hit;
    logic       rd_req;
    logic       rd_pend_q;
    page_idx_t  rd_page_q;
    page_idx_t  rd_page;

    logic       sel_wr;
    logic       sel_rd;
    logic       sel_mgmt;
    page_idx_t  issue_page;
    logic       issue_dsc;
    queue_idx_t issue_queue;

    table_cmd_t cmd_d [NB_TABLES];
    table_cmd_t pkt_cmd_d [NB_TABLES];
    table_cmd_t dsc_cmd_d [NB_TABLES];

    ret_tag_t   issue_tag_d;
    ret_tag_t   issue_tag_q;
    ret_tag_t   ret_q [TABLE_RD_LATENCY];
    ret_tag_t   ret_tag;
    reg_word_t  ret_word [NB_TABLES];
    mmio_data_t rd_line;

    assign mmio_page      = mmio_address[MMIO_PAGE_LSB +: PAGE_IDX_WIDTH];
    assign mmio_in_region = !mmio_address[MMIO_REGION_BIT];
    assign wr_hit         = mmio_write && mmio_in_region;

    // a new read or one that lost against a write earlier
    assign rd_req  = rd_pend_q || (mmio_read && mmio_in_region);
    assign rd_page = rd_pend_q ? rd_page_q : mmio_page;

    // priority: MMIO write, MMIO read, then management
    assign sel_wr   = wr_hit;
    assign sel_rd   = !wr_hit && rd_req;
    assign sel_mgmt = !wr_hit && !rd_req && mgmt_req.valid && !mgmt_grant;

    always_comb begin
        if (sel_wr) begin
            issue_page = mmio_page;
        end else if (sel_rd) begin
            issue_page = rd_page;
        end else begin
            issue_page = mgmt_req.page;
        end
    end

    // upper half of the pages are descriptor queues
    assign issue_dsc   = issue_page >= page_idx_t'(NB_PKT_QUEUES);
    assign issue_queue = issue_page[QUEUE_IDX_WIDTH-1:0];

    always_comb begin
        for (int t = 0; t < NB_TABLES; t++) begin
            cmd_d[t].addr    = issue_queue;
            cmd_d[t].wr_data = sel_wr ? mmio_writedata[t*REG_WIDTH +: REG_WIDTH]
                                      : mgmt_req.data;
            // host reads always fetch the whole queue entry
            cmd_d[t].rd_en   = sel_rd ||
                (sel_mgmt && !mgmt_req.write && mgmt_req.sel == table_sel_t'(t));
            // only fully enabled dwords, tails excluded
            cmd_d[t].wr_en   =
                (sel_wr && table_sel_t'(t) != TBL_TAILS &&
                 (&mmio_byteenable[t*BE_PER_WORD +: BE_PER_WORD])) ||
                (sel_mgmt && mgmt_req.write && mgmt_req.sel == table_sel_t'(t));

            pkt_cmd_d[t]       = cmd_d[t];
            pkt_cmd_d[t].rd_en = cmd_d[t].rd_en && !issue_dsc;
            pkt_cmd_d[t].wr_en = cmd_d[t].wr_en && !issue_dsc;
            dsc_cmd_d[t]       = cmd_d[t];
            dsc_cmd_d[t].rd_en = cmd_d[t].rd_en && issue_dsc;
            dsc_cmd_d[t].wr_en = cmd_d[t].wr_en && issue_dsc;
        end
    end

    always_comb begin
        issue_tag_d.valid = sel_rd || (sel_mgmt && !mgmt_req.write);
        issue_tag_d.mmio  = sel_rd;
        issue_tag_d.dsc   = issue_dsc;
        issue_tag_d.sel   = mgmt_req.sel;
    end

    // commands and grant are registered, the memory sees them one cycle later
    always_ff @(posedge pcie_clk) begin
        for (int t = 0; t < NB_TABLES; t++) begin
            pkt_cmd[t] <= pkt_cmd_d[t];
            dsc_cmd[t] <= dsc_cmd_d[t];
        end
        rd_page_q <= rd_page;
        if (!pcie_reset_n) begin
            for (int t = 0; t < NB_TABLES; t++) begin
                pkt_cmd[t].rd_en <= 1'b0;
                pkt_cmd[t].wr_en <= 1'b0;
                dsc_cmd[t].rd_en <= 1'b0;
                dsc_cmd[t].wr_en <= 1'b0;
            end
            mgmt_grant <= 1'b0;
            rd_pend_q  <= 1'b0;
        end else begin
            mgmt_grant <= sel_mgmt;
            // a read blocked by a write stays pending
            rd_pend_q  <= rd_req && wr_hit;
        end
    end

    // return pipeline, last stage lines up with the memory output
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            issue_tag_q <= '0;
            for (int i = 0; i < TABLE_RD_LATENCY; i++) begin
                ret_q[i] <= '0;
            end
        end else begin
            issue_tag_q <= issue_tag_d;
            ret_q[0]    <= issue_tag_q;
            for (int i = 1; i < TABLE_RD_LATENCY; i++) begin
                ret_q[i] <= ret_q[i-1];
            end
        end
    end

    assign ret_tag = ret_q[TABLE_RD_LATENCY-1];

    always_comb begin
        rd_line = '0;
        for (int t = 0; t < NB_TABLES; t++) begin
            ret_word[t] = ret_tag.dsc ? dsc_rd_data[t] : pkt_rd_data[t];
            rd_line[t*REG_WIDTH +: REG_WIDTH] = ret_word[t];
        end
    end

    // management reads take the word straight from the memory
    assign mgmt_rd_valid = ret_tag.valid && !ret_tag.mmio;
    assign mgmt_rd_data  = ret_word[ret_tag.sel];

    always_ff @(posedge pcie_clk) begin
        if (ret_tag.valid && ret_tag.mmio) begin
            mmio_readdata <= rd_line;
        end
        if (!pcie_reset_n) begin
            mmio_readdatavalid <= 1'b0;
        end else begin
            mmio_readdatavalid <= ret_tag.valid && ret_tag.mmio;
        end
    end

endmodule

/* arbiter/mgmt_apb_regs.sv */
`timescale 1ns/100ps

module mgmt_apb_regs import queue_table_pkg::*; (
    input  logic       pcie_clk,
    input  logic       pcie_reset_n,

    // APB3 slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  reg_word_t  pwdata,
    output reg_word_t  prdata,
    output logic       pready,
    output logic       pslverr,

    // table access through the arbiter
    output mgmt_req_t  mgmt_req,
    input  logic       mgmt_grant,
    input  logic       mgmt_rd_valid,
    input  reg_word_t  mgmt_rd_data,

    output ctrl_regs_t control_regs
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DATA,
        DONE
    } apb_state_t;

    apb_state_t                state;
    logic                      setup;
    logic [APB_WORD_WIDTH-1:0] word_idx;
    logic [APB_WORD_WIDTH-1:0] table_off;
    logic                      is_ctrl;
    logic                      is_table;
    table_sel_t                req_sel;
    page_idx_t                 req_page;

    assign setup    = psel && !penable;
    assign word_idx = paddr[APB_ADDR_WIDTH-1:APB_WORD_LSB];
    assign is_ctrl  = word_idx < APB_WORD_WIDTH'(NB_CONTROL_REGS);
    assign is_table = !is_ctrl && word_idx < APB_WORD_WIDTH'(MGMT_TABLE_END);

    // table words are laid out page by page, four tables each
    assign table_off = word_idx - APB_WORD_WIDTH'(MGMT_TABLE_BASE);
    assign req_sel   = table_off[TABLE_SEL_WIDTH-1:0];
    assign req_page  = table_off[TABLE_SEL_WIDTH +: PAGE_IDX_WIDTH];

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state          <= IDLE;
            pready         <= 1'b0;
            pslverr        <= 1'b0;
            mgmt_req.valid <= 1'b0;
            control_regs   <= '0;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            case (state)
                IDLE: begin
                    if (setup) begin
                        if (is_ctrl) begin
                            // control registers answer right away
                            if (pwrite) begin
                                control_regs[word_idx[CTRL_IDX_WIDTH-1:0]] <= pwdata;
                            end else begin
                                prdata <= control_regs[word_idx[CTRL_IDX_WIDTH-1:0]];
                            end
                            pready <= 1'b1;
                            state  <= DONE;
                        end else if (is_table) begin
                            mgmt_req.valid <= 1'b1;
                            mgmt_req.write <= pwrite;
                            mgmt_req.sel   <= req_sel;
                            mgmt_req.page  <= req_page;
                            mgmt_req.data  <= pwdata;
                            state          <= REQ;
                        end else begin
                            // unmapped word
                            prdata  <= '0;
                            pready  <= 1'b1;
                            pslverr <= 1'b1;
                            state   <= DONE;
                        end
                    end
                end
                REQ: begin
                    // request stays up until the arbiter takes it
                    if (mgmt_grant) begin
                        mgmt_req.valid <= 1'b0;
                        if (mgmt_req.write) begin
                            pready <= 1'b1;
                            state  <= DONE;
                        end else begin
                            state <= WAIT_DATA;
                        end
                    end
                end
                WAIT_DATA: begin
                    if (mgmt_rd_valid) begin
                        prdata <= mgmt_rd_data;
                        pready <= 1'b1;
                        state  <= DONE;
                    end
                end
                DONE: begin
                    // access phase completes in this cycle
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/queue_table_top.sv */
`timescale 1ns/100ps

module queue_table_top import queue_table_pkg::*; (
    input  logic       pcie_clk,
    input  logic       pcie_reset_n,

    // host MMIO
    input  mmio_addr_t mmio_address,
    input  logic       mmio_write,
    input  logic       mmio_read,
    input  mmio_data_t mmio_writedata,
    input  mmio_be_t   mmio_byteenable,
    output mmio_data_t mmio_readdata,
    output logic       mmio_readdatavalid,

    // APB management
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  reg_word_t  pwdata,
    output reg_word_t  prdata,
    output logic       pready,
    output logic       pslverr,

    output ctrl_regs_t control_regs
);

    mgmt_req_t  mgmt_req;
    logic       mgmt_grant;
    logic       mgmt_rd_valid;
    reg_word_t  mgmt_rd_data;

    table_cmd_t pkt_cmd [NB_TABLES];
    table_cmd_t dsc_cmd [NB_TABLES];
    reg_word_t  pkt_rd_data [NB_TABLES];
    reg_word_t  dsc_rd_data [NB_TABLES];

    table_port_arbiter u_arbiter (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .mmio_address       (mmio_address),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_writedata     (mmio_writedata),
        .mmio_byteenable    (mmio_byteenable),
        .mmio_readdata      (mmio_readdata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .mgmt_req           (mgmt_req),
        .mgmt_grant         (mgmt_grant),
        .mgmt_rd_valid      (mgmt_rd_valid),
        .mgmt_rd_data       (mgmt_rd_data),
        .pkt_cmd            (pkt_cmd),
        .dsc_cmd            (dsc_cmd),
        .pkt_rd_data        (pkt_rd_data),
        .dsc_rd_data        (dsc_rd_data)
    );

    mgmt_apb_regs u_mgmt (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .mgmt_req      (mgmt_req),
        .mgmt_grant    (mgmt_grant),
        .mgmt_rd_valid (mgmt_rd_valid),
        .mgmt_rd_data  (mgmt_rd_data),
        .control_regs  (control_regs)
    );

    // tails, heads, low and high address for each bank
    for (genvar t = 0; t < NB_TABLES; t++) begin : g_table
        queue_table_ram u_pkt_ram (
            .pcie_clk (pcie_clk),
            .cmd      (pkt_cmd[t]),
            .rd_data  (pkt_rd_data[t])
        );

        queue_table_ram u_dsc_ram (
            .pcie_clk (pcie_clk),
            .cmd      (dsc_cmd[t]),
            .rd_data  (dsc_rd_data[t])
        );
    end

endmodule

/* testbench/queue_table_chk.sv */
`timescale 1ns/100ps

module queue_table_chk import queue_table_pkg::*; (
    input logic       pcie_clk,
    input logic       pcie_reset_n,
    input table_cmd_t pkt_cmd [NB_TABLES],
    input table_cmd_t dsc_cmd [NB_TABLES],
    input mgmt_req_t  mgmt_req,
    input logic       mgmt_grant,
    input logic       mmio_readdatavalid,
    input logic       pready,
    input logic       pslverr
);

    int   assert_errors = 0;
    logic cmd_clash;

    // any memory that sees a read and a write in the same cycle
    always_comb begin
        cmd_clash = 1'b0;
        for (int t = 0; t < NB_TABLES; t++) begin
            cmd_clash = cmd_clash || (pkt_cmd[t].rd_en && pkt_cmd[t].wr_en) ||
                        (dsc_cmd[t].rd_en && dsc_cmd[t].wr_en);
        end
    end

    a_no_cmd_clash: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        !cmd_clash)
    else begin
        assert_errors++;
        $error("table command with rd_en and wr_en together");
    end

    a_grant_with_req: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        mgmt_grant |-> mgmt_req.valid)
    else begin
        assert_errors++;
        $error("mgmt_grant without a valid management request");
    end

    // the host waits for each read, so valid is a single-cycle pulse
    a_single_valid: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        mmio_readdatavalid |=> !mmio_readdatavalid)
    else begin
        assert_errors++;
        $error("mmio_readdatavalid high in two consecutive cycles");
    end

    a_err_with_ready: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        pslverr |-> pready)
    else begin
        assert_errors++;
        $error("pslverr without pready");
    end

endmodule

// top level scope sees both the arbiter signals and the APB response
bind queue_table_top queue_table_chk u_chk (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .pkt_cmd            (pkt_cmd),
    .dsc_cmd            (dsc_cmd),
    .mgmt_req           (mgmt_req),
    .mgmt_grant         (mgmt_grant),
    .mmio_readdatavalid (mmio_readdatavalid),
    .pready             (pready),
    .pslverr            (pslverr)
);

/* testbench/tb_queue_table.sv */
`timescale 1ns/100ps

module tb_queue_table import queue_table_pkg::*; ();

    localparam int    WAIT_LIMIT = 300;
    localparam string CASE_FILE  = "testbench/queue_table_cases.txt";

    logic       pcie_clk = 1'b0;
    logic       pcie_reset_n;
    mmio_addr_t mmio_address;
    logic       mmio_write;
    logic       mmio_read;
    mmio_data_t mmio_writedata;
    mmio_be_t   mmio_byteenable;
    mmio_data_t mmio_readdata;
    logic       mmio_readdatavalid;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    reg_word_t  pwdata;
    reg_word_t  prdata;
    logic       pready;
    logic       pslverr;
    ctrl_regs_t control_regs;

    // expected table contents, indexed by page then table
    reg_word_t   shadow [NB_PKT_QUEUES + NB_DSC_QUEUES][NB_TABLES];
    logic [31:0] lfsr_state  = 32'h095c25dc;
    int          error_count = 0;
    int          check_count = 0;

    always #4 pcie_clk = ~pcie_clk;

    queue_table_top UUT (.*);

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %0d ns %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output logic [127:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[126:0], lfsr_state[0]};
        end
    endtask

    function automatic reg_word_t fill_word(input int page, input int sel);
        return 32'h5a5a_0000 | (page << 8) | sel;
    endfunction

    function automatic logic [127:0] expected_line(input page_idx_t page);
        return {shadow[page][3], shadow[page][2], shadow[page][1], shadow[page][0]};
    endfunction

    task automatic record_write(input mmio_addr_t addr, input logic [127:0] data,
                                input logic [15:0] be);
        if (!addr[MMIO_REGION_BIT]) begin
            // tails is left alone, other dwords need all four byte enables
            for (int t = 1; t < NB_TABLES; t++) begin
                if (&be[t*4 +: 4]) begin
                    shadow[addr[MMIO_PAGE_LSB +: PAGE_IDX_WIDTH]][t] = data[t*32 +: 32];
                end
            end
        end
    endtask

    // management writes reach every table, tails included
    task automatic record_apb_write(input apb_addr_t addr, input reg_word_t data);
        int word_idx;
        int off;
        word_idx = int'(addr[APB_ADDR_WIDTH-1:APB_WORD_LSB]);
        off      = word_idx - MGMT_TABLE_BASE;
        if (word_idx >= MGMT_TABLE_BASE && word_idx < MGMT_TABLE_END) begin
            shadow[off / NB_TABLES][off % NB_TABLES] = data;
        end
    endtask

    task automatic drive_mmio_write(input mmio_addr_t addr, input logic [127:0] data,
                                    input logic [15:0] be, input logic with_read);
        @(posedge pcie_clk);
        mmio_address    <= addr;
        mmio_write      <= 1'b1;
        mmio_read       <= with_read;
        mmio_writedata  <= {{(MMIO_DATA_WIDTH - 128){1'b1}}, data};
        mmio_byteenable <= {{(MMIO_BE_WIDTH - 16){1'b1}}, be};
        record_write(addr, data, be);
    endtask

    task automatic release_mmio();
        @(posedge pcie_clk);
        mmio_write <= 1'b0;
        mmio_read  <= 1'b0;
    endtask

    task automatic wait_line(output logic [511:0] line, output logic ok);
        int waited;
        waited = 0;
        @(negedge pcie_clk);
        while (!mmio_readdatavalid && waited < WAIT_LIMIT) begin
            @(negedge pcie_clk);
            waited++;
        end
        ok   = mmio_readdatavalid;
        line = mmio_readdata;
        if (!ok) begin
            error_count++;
            $display("MMIO read got no mmio_readdatavalid within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic check_mmio_read(input mmio_addr_t addr, input logic [127:0] expected);
        logic [511:0] line;
        logic         ok;
        @(posedge pcie_clk);
        mmio_address <= addr;
        mmio_read    <= 1'b1;
        @(posedge pcie_clk);
        mmio_read <= 1'b0;
        wait_line(line, ok);
        if (ok) begin
            check_value("mmio_readdata", line, {384'b0, expected});
        end
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, input reg_word_t wdata,
                              output reg_word_t rdata, output logic err, output logic ok);
        int waited;
        waited = 0;
        @(posedge pcie_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge pcie_clk);
        penable <= 1'b1;
        @(negedge pcie_clk);
        while (!pready && waited < WAIT_LIMIT) begin
            @(negedge pcie_clk);
            waited++;
        end
        ok    = pready;
        rdata = prdata;
        err   = pslverr;
        if (!ok) begin
            error_count++;
            $display("APB access to %0h got no pready within %0d cycles", addr, WAIT_LIMIT);
        end
        @(posedge pcie_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_apb(input logic wr, input apb_addr_t addr, input reg_word_t wdata,
                             input reg_word_t expected);
        reg_word_t rdata;
        logic      err;
        logic      ok;
        logic      exp_err;
        // words past the last table entry are unmapped
        exp_err = addr[APB_ADDR_WIDTH-1:APB_WORD_LSB] >= MGMT_TABLE_END;
        if (wr) begin
            record_apb_write(addr, wdata);
        end
        apb_access(wr, addr, wdata, rdata, err, ok);
        if (ok) begin
            check_value("pslverr", err, exp_err);
            if (!wr) begin
                check_value("prdata", rdata, expected);
            end
        end
    endtask

    task automatic fill_tables();
        for (int p = 0; p < NB_PKT_QUEUES + NB_DSC_QUEUES; p++) begin
            for (int s = 0; s < NB_TABLES; s++) begin
                check_apb(1'b1, apb_addr_t'((MGMT_TABLE_BASE + p * NB_TABLES + s) * 4),
                          fill_word(p, s), '0);
            end
        end
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge pcie_clk);
            check_value("pready", pready, 1'b0);
            check_value("mmio_readdatavalid", mmio_readdatavalid, 1'b0);
        end
    endtask

    task automatic run_burst(input apb_addr_t apb_addr, input int count);
        logic [127:0] bits;
        logic [127:0] data;
        logic [15:0]  be;
        logic [511:0] line;
        logic         line_ok;
        logic         apb_ok;
        logic         err;
        reg_word_t    rdata;
        mmio_addr_t   addr;
        page_idx_t    rd_page;
        int           off;
        fork
            begin
                for (int i = 0; i < count; i++) begin
                    take_random(PAGE_IDX_WIDTH, bits);
                    addr = {1'b0, bits[PAGE_IDX_WIDTH-1:0], 12'h000};
                    take_random(128, data);
                    take_random(4, bits);
                    for (int d = 0; d < 4; d++) begin
                        be[d*4 +: 4] = bits[d] ? 4'hf : 4'h6;
                    end
                    // the read rides on a write mid-burst and must stay pending
                    if (i == count / 2) begin
                        rd_page = addr[MMIO_PAGE_LSB +: PAGE_IDX_WIDTH];
                    end
                    drive_mmio_write(addr, data, be, i == count / 2);
                end
                release_mmio();
                wait_line(line, line_ok);
            end
            begin
                repeat (2) @(posedge pcie_clk);
                apb_access(1'b0, apb_addr, '0, rdata, err, apb_ok);
            end
        join
        off = int'(apb_addr[APB_ADDR_WIDTH-1:APB_WORD_LSB]) - MGMT_TABLE_BASE;
        if (line_ok) begin
            check_value("mmio_readdata", line, {384'b0, expected_line(rd_page)});
        end
        if (apb_ok) begin
            check_value("pslverr", err, 1'b0);
            check_value("prdata", rdata, shadow[off / NB_TABLES][off % NB_TABLES]);
        end
        // every page again, so a lost write shows up
        for (int p = 0; p < NB_PKT_QUEUES + NB_DSC_QUEUES; p++) begin
            check_mmio_read({1'b0, page_idx_t'(p), 12'h000}, expected_line(page_idx_t'(p)));
        end
    endtask

    task automatic run_case(input string op, input logic [127:0] addr, input logic [127:0] data,
                            input logic [127:0] be, input logic [127:0] expected);
        case (op)
            "id": idle_check(int'(data[15:0]));
            "cr": begin
                @(negedge pcie_clk);
                check_value($sformatf("control_regs[%0d]", addr[2:0]),
                            control_regs[addr[2:0]], expected[31:0]);
            end
            "aw": check_apb(1'b1, addr[APB_ADDR_WIDTH-1:0], data[31:0], '0);
            "ar": check_apb(1'b0, addr[APB_ADDR_WIDTH-1:0], '0, expected[31:0]);
            "in": fill_tables();
            "mw": begin
                drive_mmio_write(addr[MMIO_ADDR_WIDTH-1:0], data, be[15:0], 1'b0);
                release_mmio();
            end
            "mr": check_mmio_read(addr[MMIO_ADDR_WIDTH-1:0], expected);
            "bu": run_burst(addr[APB_ADDR_WIDTH-1:0], int'(data[15:0]));
            default: begin
                error_count++;
                $display("unknown operation %s in %s", op, CASE_FILE);
            end
        endcase
    endtask

    initial begin
        int           fd;
        string        text;
        string        op;
        logic [127:0] addr;
        logic [127:0] data;
        logic [127:0] be;
        logic [127:0] expected;
        pcie_reset_n    = 1'b0;
        mmio_address    = '0;
        mmio_write      = 1'b0;
        mmio_read       = 1'b0;
        mmio_writedata  = '0;
        mmio_byteenable = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        repeat (3) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("cannot open the case file %s", CASE_FILE);
        end else begin
            while (!$feof(fd)) begin
                text = "";
                if ($fgets(text, fd) != 0) begin
                    // comment and blank lines do not parse into five fields
                    if ($sscanf(text, "%s %h %h %h %h", op, addr, data, be, expected) == 5) begin
                        run_case(op, addr, data, be, expected);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (4) @(posedge pcie_clk);
        error_count += UUT.u_chk.assert_errors;
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/queue_table_cases.txt */
# op addr data be expect, all hex; MMIO data and expect hold dwords 3..0, be their 16 enables
# id: data = idle cycles; cr: addr = register; in: fill tables; bu: addr = APB read, data = writes
id 0 10 0 0
cr 0 0 0 0
cr 1 0 0 0
cr 2 0 0 0
cr 3 0 0 0
cr 4 0 0 0
cr 5 0 0 0
cr 6 0 0 0
cr 7 0 0 0
aw 000 11110000 0 0
aw 00c 3333cccc 0 0
aw 01c 7777eeee 0 0
cr 0 0 0 11110000
cr 3 0 0 3333cccc
cr 7 0 0 7777eeee
cr 5 0 0 0
ar 000 0 0 11110000
ar 00c 0 0 3333cccc
ar 01c 0 0 7777eeee
aw 220 deadbeef 0 0
ar 3fc 0 0 0
cr 0 0 0 11110000
cr 7 0 0 7777eeee
in 0 0 0 0
mw 03000 d3d3d3d3c2c2c2c2b1b1b1b1a0a0a0a0 7fff 0
mr 03000 0 0 5a5a0303c2c2c2c2b1b1b1b15a5a0300
mw 14000 44444444333333332222222211111111 f0ff 0
mr 14000 0 0 444444445a5a1402222222225a5a1400
mr 04000 0 0 5a5a04035a5a04025a5a04015a5a0400
mw 23000 eeeeeeeeeeeeeeeeeeeeeeeeeeeeeeee ffff 0
mr 03000 0 0 5a5a0303c2c2c2c2b1b1b1b15a5a0300
aw 070 cafe0005 0 0
aw 174 beef0015 0 0
mr 05000 0 0 5a5a05035a5a05025a5a0501cafe0005
mr 15000 0 0 5a5a15035a5a1502beef00155a5a1500
ar 050 0 0 5a5a0300
ar 054 0 0 b1b1b1b1
ar 16c 0 0 44444444
ar 21c 0 0 5a5a1f03
ar 220 0 0 0
bu 054 18 0 0
bu 16c 30 0 0

/* sim.f */
common/queue_table_pkg.sv
verilog/queue_table_ram.sv
arbiter/table_port_arbiter.sv
arbiter/mgmt_apb_regs.sv
verilog/queue_table_top.sv
testbench/queue_table_chk.sv
testbench/tb_queue_table.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_queue_table -f sim.f -o Vtb_queue_table

# assertion errors must not stop the run before the result line
./obj_dir/Vtb_queue_table +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
